//--- common/raster_pkg.sv
// shared constants and types for the triangle rasterizer
// frame is 320x240 RGB332, vertices must lie inside the frame
// edge widths are sized for coordinates below 320 and 240 only

package raster_pkg;

  //////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////

  // pixel column, 0..319
  typedef logic [8:0] coord_x_t;
  // pixel row, 0..239
  typedef logic [7:0] coord_y_t;
  // display drawX / drawY, full 640x480 timing
  typedef logic [9:0] draw_coord_t;
  // RGB332 pixel
  typedef logic [7:0] color_t;
  // one 4-bit output channel
  typedef logic [3:0] channel_t;
  // row * 320 + column
  typedef logic [16:0] fb_addr_t;

  // edge coefficients, |a| <= 239 and |b| <= 319
  typedef logic signed [9:0] edge_coef_t;
  // edge constant, |c| <= 319 * 239
  typedef logic signed [17:0] edge_const_t;
  // a*x + b*y + c for one pixel
  typedef logic signed [19:0] edge_val_t;

  //////////////////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////////////////

  localparam int FB_WIDTH = 320;
  localparam int FB_HEIGHT = 240;
  localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;
  // written to every word during a clear
  localparam color_t CLEAR_COLOR = 8'h00;

  //////////////////////////////////////////////////////////////
  // structs and state
  //////////////////////////////////////////////////////////////

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } vertex_t;

  // v[0], v[1], v[2] are vertices 1, 2, 3
  typedef struct packed {
    vertex_t [2:0] v;
    color_t color;
  } triangle_t;

  typedef struct packed {
    edge_coef_t a;
    edge_coef_t b;
    edge_const_t c;
  } edge_t;

  // edges[0..2] are 1->2, 2->3, 3->1; box limits inclusive
  typedef struct packed {
    edge_t [2:0] edges;
    coord_x_t min_x;
    coord_x_t max_x;
    coord_y_t min_y;
    coord_y_t max_y;
    color_t color;
  } setup_t;

  typedef struct packed {
    logic we;
    fb_addr_t addr;
    color_t data;
  } fb_write_t;

  typedef enum logic [1:0] {
    clear_buf,
    wait_tri,
    calc_edge,
    rasterize
  } ctrl_state_t;

endpackage

//--- raster/edge_setup.sv
// edge equations and bounding box for one triangle, two stages
// tri_held must stay stable from edge_start until edge_done
// edge_done follows edge_start by exactly 2 cycles
`timescale 1ns/10ps

module edge_setup (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  raster_pkg::triangle_t   tri_held,
  input  logic                    edge_start,
  output raster_pkg::setup_t      setup,
  output logic                    edge_done
);

  // stage one results
  raster_pkg::edge_coef_t a_s1 [3];
  raster_pkg::edge_coef_t b_s1 [3];
  // cross products P.x*Q.y and Q.x*P.y, at most 319*239
  logic [16:0] pq_s1 [3];
  logic [16:0] qp_s1 [3];
  raster_pkg::coord_x_t min_x_s1;
  raster_pkg::coord_x_t max_x_s1;
  raster_pkg::coord_y_t min_y_s1;
  raster_pkg::coord_y_t max_y_s1;
  logic stage1_valid;

  function automatic logic [8:0] min3(input logic [8:0] p, input logic [8:0] q,
                                      input logic [8:0] r);
    logic [8:0] m;
    m = (p < q) ? p : q;
    return (m < r) ? m : r;
  endfunction

  function automatic logic [8:0] max3(input logic [8:0] p, input logic [8:0] q,
                                      input logic [8:0] r);
    logic [8:0] m;
    m = (p > q) ? p : q;
    return (m > r) ? m : r;
  endfunction

  ////////////////////////////////////////////////////////////
  // stage one, a, b, products and box
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (edge_start) begin
      // edge i runs from vertex i to vertex i+1, wrapping
      for (int i = 0; i < 3; i++) begin
        a_s1[i] <= $signed({2'b00, tri_held.v[i].y}) - $signed({2'b00, tri_held.v[(i+1)%3].y});
        b_s1[i] <= $signed({1'b0, tri_held.v[(i+1)%3].x}) - $signed({1'b0, tri_held.v[i].x});
        pq_s1[i] <= tri_held.v[i].x * tri_held.v[(i+1)%3].y;
        qp_s1[i] <= tri_held.v[(i+1)%3].x * tri_held.v[i].y;
      end
      min_x_s1 <= min3(tri_held.v[0].x, tri_held.v[1].x, tri_held.v[2].x);
      max_x_s1 <= max3(tri_held.v[0].x, tri_held.v[1].x, tri_held.v[2].x);
      // y is zero-extended into the shared helpers
      min_y_s1 <= raster_pkg::coord_y_t'(min3({1'b0, tri_held.v[0].y},
                                               {1'b0, tri_held.v[1].y},
                                               {1'b0, tri_held.v[2].y}));
      max_y_s1 <= raster_pkg::coord_y_t'(max3({1'b0, tri_held.v[0].y},
                                               {1'b0, tri_held.v[1].y},
                                               {1'b0, tri_held.v[2].y}));
    end
  end

  ////////////////////////////////////////////////////////////
  // stage two, c and final setup
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (stage1_valid) begin
      for (int i = 0; i < 3; i++) begin
        setup.edges[i].a <= a_s1[i];
        setup.edges[i].b <= b_s1[i];
        setup.edges[i].c <= $signed({1'b0, pq_s1[i]}) - $signed({1'b0, qp_s1[i]});
      end
      setup.min_x <= min_x_s1;
      setup.max_x <= max_x_s1;
      setup.min_y <= min_y_s1;
      setup.max_y <= max_y_s1;
      setup.color <= tri_held.color;
    end
  end

  // two-deep valid pipe
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      stage1_valid <= 1'b0;
      edge_done <= 1'b0;
    end else begin
      stage1_valid <= edge_start;
      edge_done <= stage1_valid;
    end
  end

endmodule

//--- raster/pixel_walker.sv
// walks the bounding box row by row at one pixel per clock
// setup must stay stable from walk_start until walk_done
// writes are registered; walk_done comes one cycle after the last write slot
`timescale 1ns/10ps

module pixel_walker (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  raster_pkg::setup_t      setup,
  input  logic                    walk_start,
  output raster_pkg::fb_write_t   walk_wr,
  output logic                    walk_done
);

  // current pixel
  raster_pkg::coord_x_t col;
  raster_pkg::coord_y_t row;
  logic active;
  // last pixel was issued on the previous clock
  logic last_q;

  raster_pkg::edge_val_t ev [3];
  logic all_pos;
  logic all_neg;
  logic in_tri;
  logic last_px;
  raster_pkg::fb_addr_t pix_addr;

  // a*x + b*y + c in signed arithmetic
  function automatic raster_pkg::edge_val_t edge_eval(input raster_pkg::edge_t e,
                                                      input raster_pkg::coord_x_t x,
                                                      input raster_pkg::coord_y_t y);
    raster_pkg::edge_val_t ax;
    raster_pkg::edge_val_t by;
    raster_pkg::edge_val_t cc;
    ax = $signed(e.a) * $signed({1'b0, x});
    by = $signed(e.b) * $signed({1'b0, y});
    cc = $signed(e.c);
    return ax + by + cc;
  endfunction

  ////////////////////////////////////////////////////////////
  // inside test
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      ev[i] = edge_eval(setup.edges[i], col, row);
    end
  end

  // either winding counts and pixels on an edge are inside
  assign all_pos = (ev[0] >= 0) && (ev[1] >= 0) && (ev[2] >= 0);
  assign all_neg = (ev[0] <= 0) && (ev[1] <= 0) && (ev[2] <= 0);
  assign in_tri = all_pos || all_neg;

  assign last_px = (col == setup.max_x) && (row == setup.max_y);

  assign pix_addr = raster_pkg::fb_addr_t'(row) * raster_pkg::fb_addr_t'(raster_pkg::FB_WIDTH) +
                    raster_pkg::fb_addr_t'(col);

  ////////////////////////////////////////////////////////////
  // walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    walk_wr.addr <= pix_addr;
    walk_wr.data <= setup.color;
    if (!S_AXI_ARESETN) begin
      active <= 1'b0;
      last_q <= 1'b0;
      walk_done <= 1'b0;
      walk_wr.we <= 1'b0;
    end else begin
      walk_wr.we <= active && in_tri;
      last_q <= active && last_px;
      walk_done <= last_q;
      if (walk_start) begin
        active <= 1'b1;
        col <= setup.min_x;
        row <= setup.min_y;
      end else if (active) begin
        // single-pixel box ends here on its first step
        if (last_px) begin
          active <= 1'b0;
        end else if (col == setup.max_x) begin
          col <= setup.min_x;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/framebuffer.sv
// simple dual-port frame buffer, 76,800 x 8 bits
// one write port, one read port with a single cycle of read latency
// contents are undefined until the controller has cleared them
`timescale 1ns/10ps

module framebuffer (
  input  logic                    S_AXI_ACLK,
  input  raster_pkg::fb_write_t   fb_wr,
  input  raster_pkg::fb_addr_t    rd_addr,
  output raster_pkg::color_t      rd_data
);

  // one RGB332 word per pixel, row major
  raster_pkg::color_t mem [raster_pkg::FB_DEPTH];

  // write side, from clear counter or walker
  always_ff @(posedge S_AXI_ACLK) begin
    if (fb_wr.we) begin
      mem[fb_wr.addr] <= fb_wr.data;
    end
  end

  // read side, registered for block RAM inference
  always_ff @(posedge S_AXI_ACLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/scanout.sv
// reads the frame buffer at half resolution for 640x480 display timing
// draw coordinates outside 640x480 give black
// outputs lag draw_x / draw_y by 2 clocks
`timescale 1ns/10ps

module scanout (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  raster_pkg::draw_coord_t   draw_x,
  input  raster_pkg::draw_coord_t   draw_y,
  input  raster_pkg::color_t        rd_data,
  output raster_pkg::fb_addr_t      rd_addr,
  output raster_pkg::channel_t      red,
  output raster_pkg::channel_t      green,
  output raster_pkg::channel_t      blue
);

  logic in_range;
  // lines up with rd_data
  logic in_range_q;

  assign in_range = (draw_x < 2 * raster_pkg::FB_WIDTH) && (draw_y < 2 * raster_pkg::FB_HEIGHT);

  // (drawY/2) * 320 + drawX/2, parked at 0 in blanking
  assign rd_addr = in_range ?
      raster_pkg::fb_addr_t'(draw_y[9:1]) * raster_pkg::fb_addr_t'(raster_pkg::FB_WIDTH) +
      raster_pkg::fb_addr_t'(draw_x[9:1]) : '0;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      in_range_q <= 1'b0;
      red <= '0;
      green <= '0;
      blue <= '0;
    end else begin
      in_range_q <= in_range;
      // RGB332 widened to 4 bits per channel, low bits zero
      red <= in_range_q ? {rd_data[7:5], 1'b0} : '0;
      green <= in_range_q ? {rd_data[4:2], 1'b0} : '0;
      blue <= in_range_q ? {rd_data[1:0], 2'b00} : '0;
    end
  end

endmodule

//--- hdl/frame_controller.sv
// sequences clear, triangle accept, edge setup and rasterization
// vsync is treated as asynchronous; only edges seen in wait_tri count
// the frame-buffer write port belongs to the clear counter in clear_buf
`timescale 1ns/10ps

module frame_controller (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  logic                    vsync,
  input  raster_pkg::triangle_t   tri_in,
  input  logic                    tri_valid,
  input  logic                    edge_done,
  input  logic                    walk_done,
  input  raster_pkg::fb_write_t   walk_wr,
  output logic                    tri_ready,
  output raster_pkg::triangle_t   tri_held,
  output logic                    edge_start,
  output logic                    walk_start,
  output raster_pkg::fb_write_t   fb_wr
);

  raster_pkg::ctrl_state_t state;
  raster_pkg::fb_addr_t clear_cnt;

  // vsync synchronizer and edge detect
  logic vsync_s1;
  logic vsync_s2;
  logic vsync_prev;
  logic vsync_rise;
  logic clear_last;

  ////////////////////////////////////////////////////////////
  // vsync
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      vsync_s1 <= 1'b0;
      vsync_s2 <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      vsync_s1 <= vsync;
      vsync_s2 <= vsync_s1;
      vsync_prev <= vsync_s2;
    end
  end

  assign vsync_rise = vsync_s2 && !vsync_prev;

  // held low on a vsync edge so a triangle is never dropped by a clear
  assign tri_ready = (state == raster_pkg::wait_tri) && !vsync_rise;

  assign clear_last = (clear_cnt == raster_pkg::fb_addr_t'(raster_pkg::FB_DEPTH - 1));

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state <= raster_pkg::clear_buf;
      clear_cnt <= '0;
      edge_start <= 1'b0;
      walk_start <= 1'b0;
    end else begin
      // start strobes are one cycle wide
      edge_start <= 1'b0;
      walk_start <= 1'b0;
      case (state)
        raster_pkg::clear_buf: begin
          // counter wraps to zero, ready for the next clear
          if (clear_last) begin
            clear_cnt <= '0;
            state <= raster_pkg::wait_tri;
          end else begin
            clear_cnt <= clear_cnt + 1'b1;
          end
        end
        raster_pkg::wait_tri: begin
          if (vsync_rise) begin
            state <= raster_pkg::clear_buf;
          end else if (tri_valid) begin
            edge_start <= 1'b1;
            state <= raster_pkg::calc_edge;
          end
        end
        raster_pkg::calc_edge: begin
          if (edge_done) begin
            walk_start <= 1'b1;
            state <= raster_pkg::rasterize;
          end
        end
        raster_pkg::rasterize: begin
          if (walk_done) begin
            state <= raster_pkg::wait_tri;
          end
        end
        default: state <= raster_pkg::clear_buf;
      endcase
    end
  end

  // accepted triangle stays put until the walker is done
  always_ff @(posedge S_AXI_ACLK) begin
    if (tri_valid && tri_ready) begin
      tri_held <= tri_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // write port mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (state == raster_pkg::clear_buf) begin
      fb_wr.we = 1'b1;
      fb_wr.addr = clear_cnt;
      fb_wr.data = raster_pkg::CLEAR_COLOR;
    end else begin
      fb_wr = walk_wr;
    end
  end

endmodule

//--- hdl/tri_raster_top.sv
// flat-shaded triangle rasterizer into a 320x240 RGB332 frame buffer
// one triangle in flight, taken on tri_valid && tri_ready
// vsync rising edge while idle clears the buffer (76,800 cycles)
// colour outputs lag draw_x / draw_y by 2 clocks
`timescale 1ns/10ps

module tri_raster_top (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic                      vsync,
  input  raster_pkg::draw_coord_t   draw_x,
  input  raster_pkg::draw_coord_t   draw_y,
  input  raster_pkg::triangle_t     tri_in,
  input  logic                      tri_valid,
  output logic                      tri_ready,
  output raster_pkg::channel_t      red,
  output raster_pkg::channel_t      green,
  output raster_pkg::channel_t      blue
);

  // controller to pipeline
  raster_pkg::triangle_t tri_held;
  logic edge_start;
  logic edge_done;
  logic walk_start;
  logic walk_done;

  // pipeline data
  raster_pkg::setup_t setup;
  raster_pkg::fb_write_t walk_wr;
  raster_pkg::fb_write_t fb_wr;

  // scan-out read port
  raster_pkg::fb_addr_t rd_addr;
  raster_pkg::color_t rd_data;

  frame_controller u_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .vsync         (vsync),
    .tri_in        (tri_in),
    .tri_valid     (tri_valid),
    .edge_done     (edge_done),
    .walk_done     (walk_done),
    .walk_wr       (walk_wr),
    .tri_ready     (tri_ready),
    .tri_held      (tri_held),
    .edge_start    (edge_start),
    .walk_start    (walk_start),
    .fb_wr         (fb_wr)
  );

  edge_setup u_edge (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .tri_held      (tri_held),
    .edge_start    (edge_start),
    .setup         (setup),
    .edge_done     (edge_done)
  );

  pixel_walker u_walk (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .setup         (setup),
    .walk_start    (walk_start),
    .walk_wr       (walk_wr),
    .walk_done     (walk_done)
  );

  framebuffer u_fb (
    .S_AXI_ACLK (S_AXI_ACLK),
    .fb_wr      (fb_wr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  scanout u_scan (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .draw_x        (draw_x),
    .draw_y        (draw_y),
    .rd_data       (rd_data),
    .rd_addr       (rd_addr),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

endmodule

//--- test/tri_raster_asserts.sv
// concurrent checks on controller strobes and the frame-buffer write port
// bound into frame_controller; its write port also carries the walker writes
// fail_count is read back by the testbench at the end of the run
`timescale 1ns/10ps

module tri_raster_asserts (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  raster_pkg::ctrl_state_t state,
  input  logic                    tri_ready,
  input  logic                    edge_start,
  input  logic                    edge_done,
  input  logic                    walk_start,
  input  raster_pkg::fb_write_t   fb_wr
);

  int fail_count = 0;

  // setup latency is fixed at 2 cycles
  edge_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      edge_start |-> ##2 edge_done)
    else begin
      $error("edge_done did not follow edge_start after 2 cycles");
      fail_count++;
    end

  // no done without a start 2 cycles back
  edge_origin: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      edge_done |-> $past(edge_start, 2))
    else begin
      $error("edge_done came without an edge_start 2 cycles earlier");
      fail_count++;
    end

  // no triangle may be taken during a clear
  ready_in_clear: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      (state == raster_pkg::clear_buf) |-> !tri_ready)
    else begin
      $error("tri_ready was high while the buffer was being cleared");
      fail_count++;
    end

  // start strobes are single-cycle pulses
  edge_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      edge_start |=> !edge_start)
    else begin
      $error("edge_start stayed high for more than one cycle");
      fail_count++;
    end

  walk_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      walk_start |=> !walk_start)
    else begin
      $error("walk_start stayed high for more than one cycle");
      fail_count++;
    end

  // every write lands inside the buffer
  write_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      fb_wr.we |-> (fb_wr.addr < raster_pkg::FB_DEPTH))
    else begin
      $error("frame-buffer write address is beyond the last word");
      fail_count++;
    end

endmodule

bind frame_controller tri_raster_asserts ctrl_asserts (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .state         (state),
  .tri_ready     (tri_ready),
  .edge_start    (edge_start),
  .edge_done     (edge_done),
  .walk_start    (walk_start),
  .fb_wr         (fb_wr)
);

//--- test/tb_tri_raster.sv
// testbench for tri_raster_top, random triangles from a fixed seed
// reference model keeps its own 320x240 colour array
// vertices are kept near chosen centres so boxes stay at most 81x81
// readback streams one coordinate per clock, each result checked 2 clocks later
`timescale 1ns/10ps

module tb_tri_raster;

  localparam int CLK_PERIOD = 100;
  localparam int SPREAD = 40;
  localparam int MAX_BOX = (2 * SPREAD + 1) * (2 * SPREAD + 1);
  localparam int MAX_GAP = 15;
  localparam int N_RAND = 12;
  localparam int N_OVL = 8;
  localparam int N_QUAD = 4;
  localparam int N_TRI = N_RAND + N_OVL + N_QUAD;
  localparam int N_CLEARS = 2;
  localparam int READ_CYCLES = 1024;
  // reset plus slack per triangle for setup, gaps and vsync pulses
  localparam int WATCHDOG_CYCLES = 2 * (N_CLEARS * raster_pkg::FB_DEPTH +
      N_TRI * (MAX_BOX + MAX_GAP + 32) + READ_CYCLES + 64);

  logic S_AXI_ACLK = 1'b0;
  logic S_AXI_ARESETN;
  logic vsync;
  raster_pkg::draw_coord_t draw_x;
  raster_pkg::draw_coord_t draw_y;
  raster_pkg::triangle_t tri_in;
  logic tri_valid;
  logic tri_ready;
  raster_pkg::channel_t red;
  raster_pkg::channel_t green;
  raster_pkg::channel_t blue;

  integer seed = 45;
  int err_ready = 0;
  int err_channel = 0;
  int err_total;

  // model frame buffer and pending readback work
  raster_pkg::color_t model_fb [raster_pkg::FB_DEPTH];
  raster_pkg::draw_coord_t rd_x [$];
  raster_pkg::draw_coord_t rd_y [$];
  raster_pkg::triangle_t drawn [$];

  tri_raster_top DUT (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .vsync         (vsync),
    .draw_x        (draw_x),
    .draw_y        (draw_y),
    .tri_in        (tri_in),
    .tri_valid     (tri_valid),
    .tri_ready     (tri_ready),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  initial begin
    forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  ////////////////////////////////////////////////////////////
  // helpers and model
  ////////////////////////////////////////////////////////////

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic int clamp(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  // a*x + b*y + c for the directed edge p -> q
  function automatic int edge_value(input raster_pkg::vertex_t p, input raster_pkg::vertex_t q,
                                    input int x, input int y);
    return (int'(p.y) - int'(q.y)) * x + (int'(q.x) - int'(p.x)) * y +
           int'(p.x) * int'(q.y) - int'(q.x) * int'(p.y);
  endfunction

  function automatic void model_clear();
    for (int i = 0; i < raster_pkg::FB_DEPTH; i++) begin
      model_fb[i] = raster_pkg::CLEAR_COLOR;
    end
  endfunction

  function automatic void model_draw(input raster_pkg::triangle_t t);
    int x0;
    int x1;
    int y0;
    int y1;
    int e0;
    int e1;
    int e2;
    x0 = raster_pkg::FB_WIDTH;
    x1 = 0;
    y0 = raster_pkg::FB_HEIGHT;
    y1 = 0;
    for (int i = 0; i < 3; i++) begin
      x0 = (int'(t.v[i].x) < x0) ? int'(t.v[i].x) : x0;
      x1 = (int'(t.v[i].x) > x1) ? int'(t.v[i].x) : x1;
      y0 = (int'(t.v[i].y) < y0) ? int'(t.v[i].y) : y0;
      y1 = (int'(t.v[i].y) > y1) ? int'(t.v[i].y) : y1;
    end
    for (int y = y0; y <= y1; y++) begin
      for (int x = x0; x <= x1; x++) begin
        e0 = edge_value(t.v[0], t.v[1], x, y);
        e1 = edge_value(t.v[1], t.v[2], x, y);
        e2 = edge_value(t.v[2], t.v[0], x, y);
        // either winding, edges included
        if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
          model_fb[y * raster_pkg::FB_WIDTH + x] = t.color;
        end
      end
    end
  endfunction

  // random vertices around (cx, cy), winding forced by want_pos
  function automatic raster_pkg::triangle_t make_triangle(input int cx, input int cy,
                                                          input bit want_pos);
    raster_pkg::triangle_t t;
    raster_pkg::vertex_t tmp;
    int area;
    for (int i = 0; i < 3; i++) begin
      t.v[i].x = raster_pkg::coord_x_t'(clamp(cx + rand_range(-SPREAD, SPREAD), 0,
                                              raster_pkg::FB_WIDTH - 1));
      t.v[i].y = raster_pkg::coord_y_t'(clamp(cy + rand_range(-SPREAD, SPREAD), 0,
                                              raster_pkg::FB_HEIGHT - 1));
    end
    t.color = raster_pkg::color_t'(rand_range(0, 255));
    area = edge_value(t.v[0], t.v[1], t.v[2].x, t.v[2].y);
    // swapping vertices 2 and 3 flips the winding
    if ((want_pos && area < 0) || (!want_pos && area > 0)) begin
      tmp = t.v[1];
      t.v[1] = t.v[2];
      t.v[2] = tmp;
    end
    return t;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_channel(input string name, input raster_pkg::channel_t got,
                               input raster_pkg::channel_t exp);
    if (got !== exp) begin
      err_channel++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      err_ready++;
      $display("ERR tri_ready got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // random sub-pixel, same frame-buffer word
  task automatic push_pixel(input int px, input int py);
    rd_x.push_back(raster_pkg::draw_coord_t'(2 * clamp(px, 0, 319) + rand_range(0, 1)));
    rd_y.push_back(raster_pkg::draw_coord_t'(2 * clamp(py, 0, 239) + rand_range(0, 1)));
  endtask

  // all four odd/even draw pairs of one pixel
  task automatic push_quad(input int px, input int py);
    for (int i = 0; i < 4; i++) begin
      rd_x.push_back(raster_pkg::draw_coord_t'(2 * clamp(px, 0, 319) + (i % 2)));
      rd_y.push_back(raster_pkg::draw_coord_t'(2 * clamp(py, 0, 239) + (i / 2)));
    end
  endtask

  task automatic push_random(input int n);
    repeat (n) push_pixel(rand_range(0, 319), rand_range(0, 239));
  endtask

  task automatic push_vertices();
    foreach (drawn[k]) begin
      for (int i = 0; i < 3; i++) begin
        push_pixel(int'(drawn[k].v[i].x), int'(drawn[k].v[i].y));
      end
    end
    drawn.delete();
  endtask

  // one coordinate per clock, result sampled 2 clocks later
  task automatic run_readback();
    int n;
    int addr;
    raster_pkg::color_t c;
    n = rd_x.size();
    for (int i = 0; i < n + 2; i++) begin
      @(posedge S_AXI_ACLK);
      if (i < n) begin
        draw_x <= rd_x[i];
        draw_y <= rd_y[i];
      end
      @(negedge S_AXI_ACLK);
      if (i >= 2) begin
        addr = (int'(rd_y[i-2]) / 2) * raster_pkg::FB_WIDTH + int'(rd_x[i-2]) / 2;
        c = model_fb[addr];
        check_channel("red", red, {c[7:5], 1'b0});
        check_channel("green", green, {c[4:2], 1'b0});
        check_channel("blue", blue, {c[1:0], 2'b00});
      end
    end
    rd_x.delete();
    rd_y.delete();
  endtask

  // valid held until taken, optional vsync edge while busy
  task automatic send_triangle(input raster_pkg::triangle_t t, input int gap,
                               input bit pulse_vsync);
    logic [63:0] junk;
    repeat (gap) @(posedge S_AXI_ACLK);
    @(posedge S_AXI_ACLK);
    tri_in <= t;
    tri_valid <= 1'b1;
    do begin
      @(negedge S_AXI_ACLK);
    end while (!tri_ready);
    // taken on this edge
    @(posedge S_AXI_ACLK);
    junk = {$random(seed), $random(seed)};
    tri_valid <= 1'b0;
    tri_in <= junk[58:0];
    model_draw(t);
    drawn.push_back(t);
    if (pulse_vsync) begin
      vsync <= 1'b1;
      repeat (4) @(posedge S_AXI_ACLK);
      vsync <= 1'b0;
    end
  endtask

  task automatic wait_idle();
    do begin
      @(negedge S_AXI_ACLK);
    end while (!tri_ready);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    S_AXI_ARESETN = 1'b0;
    vsync = 1'b0;
    draw_x = '0;
    draw_y = '0;
    tri_in = '0;
    tri_valid = 1'b0;
    model_clear();
    repeat (8) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    // clear after reset, ready on the last cycle only
    for (int k = 1; k <= raster_pkg::FB_DEPTH; k++) begin
      @(posedge S_AXI_ACLK);
      @(negedge S_AXI_ACLK);
      check_ready(tri_ready, k == raster_pkg::FB_DEPTH);
    end
    push_random(64);
    run_readback();

    // random triangles, alternating winding
    for (int i = 0; i < N_RAND; i++) begin
      send_triangle(make_triangle(rand_range(0, 319), rand_range(0, 239), i % 2),
                    rand_range(0, MAX_GAP), 1'b0);
    end
    wait_idle();
    push_random(128);
    push_vertices();
    run_readback();

    // overlapping stack, back to back; one vsync edge while busy
    for (int i = 0; i < N_OVL; i++) begin
      send_triangle(make_triangle(160, 120, i % 2), rand_range(0, 7), i == 3);
    end
    wait_idle();
    repeat (200) push_pixel(rand_range(120, 200), rand_range(80, 160));
    push_vertices();
    run_readback();

    // vsync edge while idle, clear timing from the drive edge
    @(posedge S_AXI_ACLK);
    vsync <= 1'b1;
    model_clear();
    for (int k = 1; k <= raster_pkg::FB_DEPTH + 3; k++) begin
      @(posedge S_AXI_ACLK);
      if (k == 8) begin
        vsync <= 1'b0;
      end
      @(negedge S_AXI_ACLK);
      check_ready(tri_ready, (k == 1) || (k == raster_pkg::FB_DEPTH + 3));
    end
    push_random(64);
    run_readback();

    // odd and even draw pairs around four centres
    for (int i = 0; i < N_QUAD; i++) begin
      send_triangle(make_triangle(80 + 160 * (i % 2), 60 + 120 * (i / 2), i % 2), 0, 1'b0);
    end
    wait_idle();
    drawn.delete();
    for (int i = 0; i < N_QUAD; i++) begin
      repeat (16) push_quad(80 + 160 * (i % 2) + rand_range(-25, 25),
                            60 + 120 * (i / 2) + rand_range(-25, 25));
    end
    run_readback();

    err_total = err_ready + err_channel + DUT.u_ctrl.ctrl_asserts.fail_count;
    $display("errors: tri_ready %0d, channels %0d, assertions %0d", err_ready, err_channel,
             DUT.u_ctrl.ctrl_asserts.fail_count);
    if (err_total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog, sized from clears, triangle boxes and readback
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
    $display("timeout after %0d clocks, the DUT stopped making progress", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- files.f
common/raster_pkg.sv
raster/edge_setup.sv
raster/pixel_walker.sv
hdl/framebuffer.sv
hdl/scanout.sv
hdl/frame_controller.sv
hdl/tri_raster_top.sv
test/tri_raster_asserts.sv
test/tb_tri_raster.sv
